// File: hdl/axi_pkg.sv
package axi_pkg;

    // bus field widths
    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_DATA_W  = 32;
    localparam int AXI_ID_W    = 4;
    localparam int AXI_LEN_W   = 4;  // axi3 style length field
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;
    localparam int AXI_RESP_W  = 2;

    // transaction ids, one per client
    localparam logic [AXI_ID_W-1:0] ID_INST = 4'd0;
    localparam logic [AXI_ID_W-1:0] ID_DATA = 4'd1;

    // burst length field is beats minus one
    localparam logic [AXI_LEN_W-1:0] LEN_LINE = 4'd3;
    localparam logic [AXI_LEN_W-1:0] LEN_WORD = 4'd0;

    localparam logic [AXI_SIZE_W-1:0]  SIZE_WORD  = 3'd2;  // 4 bytes
    localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'd1;

endpackage

// File: hdl/mem_req_pkg.sv
package mem_req_pkg;

    // line geometry seen by the refill client
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = 128;
    localparam int OFFSET_W   = 4;   // byte offset inside a line

    localparam int STRB_W     = 4;   // one strobe per byte of a word

    typedef enum logic [1:0] {
        rf_idle,
        rf_addr,
        rf_collect,
        rf_deliver
    } refill_state_e;

    typedef enum logic [2:0] {
        dt_idle,
        dt_rd_addr,
        dt_rd_wait,
        dt_wr_send,
        dt_wr_resp,
        dt_done
    } data_state_e;

    typedef enum logic {
        op_read,
        op_write
    } data_op_e;

endpackage

// File: hdl/axi_rd_if.sv
`timescale 1ns/100ps

interface axi_rd_if;

    logic                             req;
    logic [axi_pkg::AXI_ID_W-1:0]     id;
    logic [axi_pkg::AXI_ADDR_W-1:0]   addr;
    logic [axi_pkg::AXI_LEN_W-1:0]    len;
    logic                             granted;     // AR handshake for this client
    logic                             beat_valid;
    logic [axi_pkg::AXI_DATA_W-1:0]   beat_data;
    logic                             beat_last;

    modport client (
        output req, id, addr, len,
        input  granted, beat_valid, beat_data, beat_last
    );

    modport arbiter (
        input  req, id, addr, len,
        output granted, beat_valid, beat_data, beat_last
    );

endinterface

// File: hdl/axi_read_arbiter.sv
`timescale 1ns/100ps

module axi_read_arbiter (
    input  logic                              aclk,
    input  logic                              rst_n,
    axi_rd_if.arbiter                         refill,
    axi_rd_if.arbiter                         data,
    output logic [axi_pkg::AXI_ID_W-1:0]      arid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    araddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]     arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   arburst,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      rid,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    rdata,
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready
);

    logic last_data;    // data client won the previous grant
    logic owner_data;   // held AR belongs to the data client
    logic ar_hs;
    logic refill_cand;
    logic data_cand;
    logic pick_data;
    logic load;

    assign ar_hs = arvalid && arready;

    // the owner still shows req in its own handshake cycle, keep it out
    assign refill_cand = refill.req && !(ar_hs && !owner_data);
    assign data_cand   = data.req && !(ar_hs && owner_data);
    assign pick_data   = data_cand && (!refill_cand || !last_data);
    assign load        = (!arvalid || arready) && (refill_cand || data_cand);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            arvalid    <= 1'b0;
            last_data  <= 1'b0;
            owner_data <= 1'b0;
            rready     <= 1'b0;
        end else begin
            rready <= 1'b1;  // every beat is taken
            if (load) begin
                arvalid    <= 1'b1;
                owner_data <= pick_data;
                last_data  <= pick_data;
            end else if (ar_hs) begin
                arvalid <= 1'b0;
            end
        end
    end

    // holding stage
    always_ff @(posedge aclk) begin
        if (load) begin
            arid   <= pick_data ? data.id : refill.id;
            araddr <= pick_data ? data.addr : refill.addr;
            arlen  <= pick_data ? data.len : refill.len;
        end
    end

    assign arsize  = axi_pkg::SIZE_WORD;
    assign arburst = axi_pkg::BURST_INCR;

    assign refill.granted = ar_hs && !owner_data;
    assign data.granted   = ar_hs && owner_data;

    // R beats go back by id
    assign refill.beat_valid = rvalid && rready && (rid == axi_pkg::ID_INST);
    assign refill.beat_data  = rdata;
    assign refill.beat_last  = rlast;
    assign data.beat_valid   = rvalid && rready && (rid == axi_pkg::ID_DATA);
    assign data.beat_data    = rdata;
    assign data.beat_last    = rlast;

endmodule

// File: hdl/inst_refill_unit.sv
`timescale 1ns/100ps

module inst_refill_unit (
    input  logic                              aclk,
    input  logic                              rst_n,
    input  logic                              inst_req,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    inst_addr,
    output logic                              inst_rdy,
    output logic                              inst_line_valid,
    output logic [mem_req_pkg::LINE_W-1:0]    inst_line,
    axi_rd_if.client                          rd
);

    mem_req_pkg::refill_state_e state;

    logic [axi_pkg::AXI_ADDR_W-1:0]             line_addr;
    logic [axi_pkg::AXI_ADDR_W-1:0]             addr_q;
    logic [$clog2(mem_req_pkg::LINE_WORDS)-1:0] beat_cnt;
    logic [mem_req_pkg::LINE_W-1:0]             line_q;
    logic                                       accept;

    assign line_addr = {inst_addr[axi_pkg::AXI_ADDR_W-1:mem_req_pkg::OFFSET_W],
                        {mem_req_pkg::OFFSET_W{1'b0}}};

    assign inst_rdy        = (state == mem_req_pkg::rf_idle);
    assign inst_line_valid = (state == mem_req_pkg::rf_deliver);
    assign inst_line       = line_q;
    assign accept          = inst_rdy && inst_req;

    // request shows up in the accept cycle so AR can follow one cycle later
    assign rd.req  = accept || (state == mem_req_pkg::rf_addr);
    assign rd.id   = axi_pkg::ID_INST;
    assign rd.addr = inst_rdy ? line_addr : addr_q;
    assign rd.len  = axi_pkg::LEN_LINE;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= mem_req_pkg::rf_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                mem_req_pkg::rf_idle: begin
                    beat_cnt <= '0;
                    if (accept)
                        state <= mem_req_pkg::rf_addr;
                end
                mem_req_pkg::rf_addr: begin
                    if (rd.granted)
                        state <= mem_req_pkg::rf_collect;
                end
                mem_req_pkg::rf_collect: begin
                    if (rd.beat_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rd.beat_last)
                            state <= mem_req_pkg::rf_deliver;
                    end
                end
                default: state <= mem_req_pkg::rf_idle;  // one cycle of line_valid
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept)
            addr_q <= line_addr;
        if (state == mem_req_pkg::rf_collect && rd.beat_valid)  // first beat in low word
            line_q[beat_cnt*axi_pkg::AXI_DATA_W +: axi_pkg::AXI_DATA_W] <= rd.beat_data;
    end

endmodule

// File: hdl/uncached_data_unit.sv
`timescale 1ns/100ps

module uncached_data_unit (
    input  logic                              aclk,
    input  logic                              rst_n,
    input  logic                              data_req,
    input  mem_req_pkg::data_op_e             data_op,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    data_addr,
    input  logic [mem_req_pkg::STRB_W-1:0]    data_wstrb,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    data_wdata,
    output logic                              data_rdy,
    output logic                              data_done,
    output logic [axi_pkg::AXI_DATA_W-1:0]    data_rdata,
    axi_rd_if.client                          rd,
    output logic [axi_pkg::AXI_ID_W-1:0]      awid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]     awlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    awsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   awburst,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [axi_pkg::AXI_ID_W-1:0]      wid,
    output logic [axi_pkg::AXI_DATA_W-1:0]    wdata,
    output logic [mem_req_pkg::STRB_W-1:0]    wstrb,
    output logic                              wlast,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      bid,
    input  logic                              bvalid,
    output logic                              bready
);

    mem_req_pkg::data_state_e state;

    logic [axi_pkg::AXI_ADDR_W-1:0]  addr_q;
    logic [mem_req_pkg::STRB_W-1:0]  wstrb_q;
    logic [axi_pkg::AXI_DATA_W-1:0]  wdata_q;
    logic                            aw_sent;
    logic                            w_sent;
    logic                            aw_done;
    logic                            w_done;
    logic                            b_hs;
    logic                            accept;

    assign data_rdy  = (state == mem_req_pkg::dt_idle);
    assign data_done = (state == mem_req_pkg::dt_done);
    assign accept    = data_rdy && data_req;

    assign rd.req  = (accept && data_op == mem_req_pkg::op_read)
                     || (state == mem_req_pkg::dt_rd_addr);
    assign rd.id   = axi_pkg::ID_DATA;
    assign rd.addr = data_rdy ? data_addr : addr_q;
    assign rd.len  = axi_pkg::LEN_WORD;

    // single beat write, AW and W leave together
    assign awid    = axi_pkg::ID_DATA;
    assign awaddr  = addr_q;
    assign awlen   = axi_pkg::LEN_WORD;
    assign awsize  = axi_pkg::SIZE_WORD;
    assign awburst = axi_pkg::BURST_INCR;
    assign awvalid = (state == mem_req_pkg::dt_wr_send) && !aw_sent;
    assign wid     = axi_pkg::ID_DATA;
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign wlast   = 1'b1;
    assign wvalid  = (state == mem_req_pkg::dt_wr_send) && !w_sent;
    assign bready  = (state == mem_req_pkg::dt_wr_resp);

    assign aw_done = aw_sent || (awvalid && awready);
    assign w_done  = w_sent || (wvalid && wready);
    assign b_hs    = bvalid && bready && (bid == axi_pkg::ID_DATA);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= mem_req_pkg::dt_idle;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            case (state)
                mem_req_pkg::dt_idle: begin
                    aw_sent <= 1'b0;
                    w_sent  <= 1'b0;
                    if (accept)
                        state <= (data_op == mem_req_pkg::op_write) ?
                                 mem_req_pkg::dt_wr_send : mem_req_pkg::dt_rd_addr;
                end
                mem_req_pkg::dt_rd_addr: begin
                    if (rd.granted)
                        state <= mem_req_pkg::dt_rd_wait;
                end
                mem_req_pkg::dt_rd_wait: begin
                    if (rd.beat_valid && rd.beat_last)
                        state <= mem_req_pkg::dt_done;
                end
                mem_req_pkg::dt_wr_send: begin
                    aw_sent <= aw_done;
                    w_sent  <= w_done;
                    if (aw_done && w_done)
                        state <= mem_req_pkg::dt_wr_resp;
                end
                mem_req_pkg::dt_wr_resp: begin
                    if (b_hs)
                        state <= mem_req_pkg::dt_done;
                end
                default: state <= mem_req_pkg::dt_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= data_addr;
            wstrb_q <= data_wstrb;
            wdata_q <= data_wdata;
        end
        if (rd.beat_valid)
            data_rdata <= rd.beat_data;  // held through the done cycle
    end

endmodule

// File: hdl/axi_mem_bridge.sv
`timescale 1ns/100ps

module axi_mem_bridge (
    input  logic                              aclk,
    input  logic                              rst_n,
    // read address and data
    output logic [axi_pkg::AXI_ID_W-1:0]      arid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    araddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]     arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   arburst,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      rid,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    rdata,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    rresp,   // not checked
    input  logic                              rlast,
    input  logic                              rvalid,
    output logic                              rready,
    // write address, data and response
    output logic [axi_pkg::AXI_ID_W-1:0]      awid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]    awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]     awlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]    awsize,
    output logic [axi_pkg::AXI_BURST_W-1:0]   awburst,
    output logic                              awvalid,
    input  logic                              awready,
    output logic [axi_pkg::AXI_ID_W-1:0]      wid,
    output logic [axi_pkg::AXI_DATA_W-1:0]    wdata,
    output logic [mem_req_pkg::STRB_W-1:0]    wstrb,
    output logic                              wlast,
    output logic                              wvalid,
    input  logic                              wready,
    input  logic [axi_pkg::AXI_ID_W-1:0]      bid,
    input  logic [axi_pkg::AXI_RESP_W-1:0]    bresp,   // not checked
    input  logic                              bvalid,
    output logic                              bready,
    // instruction line refill
    input  logic                              inst_req,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    inst_addr,
    output logic                              inst_rdy,
    output logic                              inst_line_valid,
    output logic [mem_req_pkg::LINE_W-1:0]    inst_line,
    // uncached data
    input  logic                              data_req,
    input  mem_req_pkg::data_op_e             data_op,
    input  logic [axi_pkg::AXI_ADDR_W-1:0]    data_addr,
    input  logic [mem_req_pkg::STRB_W-1:0]    data_wstrb,
    input  logic [axi_pkg::AXI_DATA_W-1:0]    data_wdata,
    output logic                              data_rdy,
    output logic                              data_done,
    output logic [axi_pkg::AXI_DATA_W-1:0]    data_rdata
);

    axi_rd_if refill_rd ();
    axi_rd_if data_rd ();

    inst_refill_unit u_refill (
        .*,
        .rd (refill_rd)
    );

    // only client on the write channels
    uncached_data_unit u_data (
        .*,
        .rd (data_rd)
    );

    axi_read_arbiter u_rd_arb (
        .*,
        .refill (refill_rd),
        .data   (data_rd)
    );

endmodule

// File: verification/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
    input  logic        aclk,
    input  logic        rst_n,
    input  logic [31:0] preload [256],
    input  logic        ar_stall,
    input  logic        r_stall,
    input  logic        aw_stall,
    input  logic        w_stall,
    input  logic        b_stall,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [3:0]  awid,
    input  logic [31:0] awaddr,
    input  logic [1:0]  awburst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [3:0]  bid,
    output logic        bvalid,
    input  logic        bready,
    output logic        proto_err
);

    logic [31:0] mem [256];
    logic [39:0] ar_q [$];   // {id, len, addr} in acceptance order
    logic [39:0] head;
    logic [7:0]  beat;
    logic [41:0] ar_seen;
    logic [37:0] aw_seen;
    logic        ar_wait;
    logic        aw_wait;
    logic        aw_got;
    logic        w_got;
    logic [3:0]  aw_id_q;
    logic [7:0]  aw_idx;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;

    assign arready = !ar_stall;
    assign awready = !aw_stall;
    assign wready  = !w_stall;

    task report_violation(input string what);
        $display("memory model: %s at %0t ns", what, $time);
        proto_err <= 1'b1;
    endtask

    always @(posedge aclk) begin
        if (!rst_n) begin
            mem = preload;
            ar_q.delete();
            beat    = '0;
            ar_wait = 1'b0;
            aw_wait = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            rid       <= '0;
            bvalid    <= 1'b0;
            bid       <= '0;
            proto_err <= 1'b0;
        end else begin
            if (ar_wait && (!arvalid || {arid, arlen, araddr, arburst} != ar_seen))
                report_violation("AR dropped or changed before arready");
            if (arvalid && arid > 4'd1)
                report_violation("AR id is neither 0 nor 1");
            if (arvalid && arburst != 2'd1)
                report_violation("AR burst is not INCR");
            ar_wait = arvalid && !arready;
            ar_seen = {arid, arlen, araddr, arburst};
            if (arvalid && arready)
                ar_q.push_back({arid, arlen, araddr});

            if (aw_wait && (!awvalid || {awid, awaddr, awburst} != aw_seen))
                report_violation("AW dropped or changed before awready");
            if (awvalid && awid > 4'd1)
                report_violation("AW id is neither 0 nor 1");
            if (awvalid && awburst != 2'd1)
                report_violation("AW burst is not INCR");
            aw_wait = awvalid && !awready;
            aw_seen = {awid, awaddr, awburst};

            // read beats, oldest burst first
            if (rvalid && rready) begin
                rvalid <= 1'b0;   // idle cycle between beats
                if (rlast) begin
                    void'(ar_q.pop_front());
                    beat = '0;
                end else begin
                    beat = beat + 8'd1;
                end
            end else if (!rvalid && ar_q.size() > 0 && !r_stall) begin
                head = ar_q[0];
                rvalid <= 1'b1;
                rid    <= head[39:36];
                rdata  <= mem[head[9:2] + beat];
                rlast  <= (beat == {4'd0, head[35:32]});
            end

            if (awvalid && awready) begin
                aw_got  = 1'b1;
                aw_id_q = awid;
                aw_idx  = awaddr[9:2];
            end
            if (wvalid && wready) begin
                w_got    = 1'b1;
                w_data_q = wdata;
                w_strb_q = wstrb;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (!bvalid && aw_got && w_got && !b_stall) begin
                for (int i = 0; i < 4; i++)
                    if (w_strb_q[i])
                        mem[aw_idx][8*i +: 8] = w_data_q[8*i +: 8];
                bvalid <= 1'b1;
                bid    <= aw_id_q;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
        end
    end

endmodule

// File: verification/axi_mem_bridge_tb.sv
`timescale 1ns/100ps

module axi_mem_bridge_tb;

    localparam int MEM_WORDS  = 256;
    localparam int SEED       = 45;
    localparam int WAIT_LIMIT = 500;   // cycles per wait loop
    localparam int MIXED_RUNS = 40;

    logic                          aclk;
    logic                          rst_n;
    logic [3:0]                    arid;
    logic [31:0]                   araddr;
    logic [3:0]                    arlen;
    logic [2:0]                    arsize;
    logic [1:0]                    arburst;
    logic                          arvalid;
    logic                          arready;
    logic [3:0]                    rid;
    logic [31:0]                   rdata;
    logic [1:0]                    rresp;
    logic                          rlast;
    logic                          rvalid;
    logic                          rready;
    logic [3:0]                    awid;
    logic [31:0]                   awaddr;
    logic [3:0]                    awlen;
    logic [2:0]                    awsize;
    logic [1:0]                    awburst;
    logic                          awvalid;
    logic                          awready;
    logic [3:0]                    wid;
    logic [31:0]                   wdata;
    logic [3:0]                    wstrb;
    logic                          wlast;
    logic                          wvalid;
    logic                          wready;
    logic [3:0]                    bid;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic                          inst_req;
    logic [31:0]                   inst_addr;
    logic                          inst_rdy;
    logic                          inst_line_valid;
    logic [mem_req_pkg::LINE_W-1:0] inst_line;
    logic                          data_req;
    mem_req_pkg::data_op_e         data_op;
    logic [31:0]                   data_addr;
    logic [3:0]                    data_wstrb;
    logic [31:0]                   data_wdata;
    logic                          data_rdy;
    logic                          data_done;
    logic [31:0]                   data_rdata;
    logic                          ar_stall;
    logic                          r_stall;
    logic                          aw_stall;
    logic                          w_stall;
    logic                          b_stall;
    logic                          proto_err;
    logic [31:0]                   ref_mem [MEM_WORDS];
    logic [31:0]                   rng;
    logic                          stall_on;

    axi_mem_bridge DUT (.*);

    axi_mem_model u_mem (
        .*,
        .preload (ref_mem)   // copied into the model while in reset
    );

    always #50 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] k);
        return {k ^ 8'h3c, ~k, k + 8'h71, k};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] w;
        w = old_word;
        for (int i = 0; i < 4; i++)
            if (strb[i])
                w[8*i +: 8] = new_word[8*i +: 8];
        return w;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch at %0t ns: %s got %0h expected %0h",
                                    $time, name, got, exp));
    endtask

    // wait for the next falling edge and redraw the stalls when enabled
    task automatic tick();
        @(negedge aclk);
        if (stall_on) begin
            rng = xorshift32(rng);
            ar_stall = rng[0] & rng[1];
            r_stall  = rng[2] & rng[3];
            aw_stall = rng[4] & rng[5];
            w_stall  = rng[6] & rng[7];
            b_stall  = rng[8] & rng[9];
        end else begin
            {ar_stall, r_stall, aw_stall, w_stall, b_stall} = '0;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!(inst_rdy && data_rdy)) begin
            if (n == WAIT_LIMIT)
                stop_on_error("timed out waiting for inst_rdy and data_rdy");
            tick();
            n++;
        end
    endtask

    // up to one request per client in the same cycle and wait for both to finish
    task automatic run_pair(input logic do_inst, input logic [31:0] ia,
                            input logic do_data, input logic is_wr,
                            input logic [31:0] da, input logic [3:0] strb,
                            input logic [31:0] wd);
        int            n;
        logic          inst_seen;
        logic          data_seen;
        logic [7:0]    base;
        logic [127:0]  exp_line;
        wait_ready();
        inst_req   = do_inst;
        inst_addr  = ia;
        data_req   = do_data;
        data_op    = is_wr ? mem_req_pkg::op_write : mem_req_pkg::op_read;
        data_addr  = da;
        data_wstrb = strb;
        data_wdata = wd;
        tick();
        inst_req = 1'b0;
        data_req = 1'b0;
        if (do_inst)
            check_value("inst_rdy", 128'(inst_rdy), 128'(0));
        if (do_data)
            check_value("data_rdy", 128'(data_rdy), 128'(0));
        if (do_inst || (do_data && !is_wr))
            check_value("arvalid", 128'(arvalid), 128'(1));
        if (do_data && is_wr) begin
            check_value("awvalid", 128'(awvalid), 128'(1));
            check_value("wvalid", 128'(wvalid), 128'(1));
        end
        inst_seen = !do_inst;
        data_seen = !do_data;
        n = 0;
        while (!(inst_seen && data_seen)) begin
            if (inst_line_valid && !inst_seen) begin
                base = {ia[9:4], 2'b00};   // line aligned word index
                exp_line = {ref_mem[base + 8'd3], ref_mem[base + 8'd2],
                            ref_mem[base + 8'd1], ref_mem[base]};
                check_value("inst_line", 128'(inst_line), exp_line);
                inst_seen = 1'b1;
            end
            if (data_done && !data_seen) begin
                if (is_wr)
                    ref_mem[da[9:2]] = merge_bytes(ref_mem[da[9:2]], wd, strb);
                else
                    check_value("data_rdata", 128'(data_rdata), 128'(ref_mem[da[9:2]]));
                data_seen = 1'b1;
            end
            if (n == WAIT_LIMIT)
                stop_on_error("timed out waiting for inst_line_valid or data_done");
            tick();
            n++;
        end
    endtask

    always @(negedge aclk) begin
        if (proto_err)
            stop_on_error("memory model saw an AXI protocol violation");
        // fields the memory model ignores
        if (arvalid)
            check_value("arsize", 128'(arsize), 128'(axi_pkg::SIZE_WORD));
        if (awvalid) begin
            check_value("awlen", 128'(awlen), 128'(axi_pkg::LEN_WORD));
            check_value("awsize", 128'(awsize), 128'(axi_pkg::SIZE_WORD));
        end
        if (wvalid) begin
            check_value("wid", 128'(wid), 128'(axi_pkg::ID_DATA));
            check_value("wlast", 128'(wlast), 128'(1));
        end
    end

    initial begin
        logic [31:0] wr_addr;
        logic [3:0]  wr_strb;
        logic [31:0] wr_data;
        aclk       = 1'b0;
        rst_n      = 1'b0;
        rresp      = '0;
        bresp      = '0;
        inst_req   = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_op    = mem_req_pkg::op_read;
        data_addr  = '0;
        data_wstrb = '0;
        data_wdata = '0;
        {ar_stall, r_stall, aw_stall, w_stall, b_stall} = '0;
        stall_on   = 1'b0;
        rng        = SEED;
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = fill_word(i[7:0]);
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        tick();

        // idle outputs right after reset
        check_value("arvalid", 128'(arvalid), 128'(0));
        check_value("awvalid", 128'(awvalid), 128'(0));
        check_value("wvalid", 128'(wvalid), 128'(0));
        check_value("inst_line_valid", 128'(inst_line_valid), 128'(0));
        check_value("data_done", 128'(data_done), 128'(0));
        check_value("inst_rdy", 128'(inst_rdy), 128'(1));
        check_value("data_rdy", 128'(data_rdy), 128'(1));

        rng = xorshift32(rng);
        run_pair(1'b1, {22'd0, rng[9:0]}, 1'b0, 1'b0, 32'd0, 4'd0, 32'd0);
        rng = xorshift32(rng);
        run_pair(1'b0, 32'd0, 1'b1, 1'b0, {22'd0, rng[9:2], 2'b00}, 4'd0, 32'd0);

        rng = xorshift32(rng);
        wr_addr = {22'd0, rng[9:2], 2'b00};
        wr_strb = rng[13:10];
        rng = xorshift32(rng);
        wr_data = rng;
        run_pair(1'b0, 32'd0, 1'b1, 1'b1, wr_addr, wr_strb, wr_data);
        run_pair(1'b0, 32'd0, 1'b1, 1'b0, wr_addr, 4'd0, 32'd0);   // merged word back

        stall_on = 1'b1;
        for (int k = 0; k < MIXED_RUNS; k++) begin
            rng = xorshift32(rng);
            if (k % 5 == 4)
                run_pair(1'b0, 32'd0, 1'b1, 1'b1, {22'd0, rng[9:2], 2'b00},
                         rng[13:10], xorshift32(rng));
            else
                run_pair(1'b1, {22'd0, rng[9:0]}, 1'b1, 1'b0,
                         {22'd0, rng[19:12], 2'b00}, 4'd0, 32'd0);
        end
        wait_ready();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: axi_mem_bridge.f
hdl/axi_pkg.sv
hdl/mem_req_pkg.sv
hdl/axi_rd_if.sv
hdl/axi_read_arbiter.sv
hdl/inst_refill_unit.sv
hdl/uncached_data_unit.sv
hdl/axi_mem_bridge.sv
verification/axi_mem_model.sv
verification/axi_mem_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run into sim.log, decide by the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/100ps --top-module axi_mem_bridge_tb \
    -f axi_mem_bridge.f -o Vaxi_mem_bridge_tb \
    && ./obj_dir/Vaxi_mem_bridge_tb > sim.log 2>&1
grep -qs '^>>> PASS$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
